//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              rst,
  input  rename_pkg::word_t instruction,
  input  logic              instr_valid,
  output rename_pkg::word_t pc,
  output logic              illegal_instr,
  decode_if.src             dec
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  legal;
  rename_pkg::alu_cmd_t  base_cmd;
  rename_pkg::alu_cmd_t  cmd;
  rename_pkg::op2_type_t op2_sel;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  // funct3 alone picks the operation class
  always_comb begin
    case (funct3)
      3'b000:  base_cmd = rename_pkg::ALU_ADD;
      3'b001:  base_cmd = rename_pkg::ALU_SLL;
      3'b010:  base_cmd = rename_pkg::ALU_SLT;
      3'b011:  base_cmd = rename_pkg::ALU_SLTU;
      3'b100:  base_cmd = rename_pkg::ALU_XOR;
      3'b101:  base_cmd = rename_pkg::ALU_SRL;
      3'b110:  base_cmd = rename_pkg::ALU_OR;
      default: base_cmd = rename_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    legal   = 1'b0;
    cmd     = rename_pkg::ALU_ADD;
    op2_sel = rename_pkg::OP2_REG;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          legal = 1'b1;
          cmd   = base_cmd;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          legal = 1'b1;
          cmd   = rename_pkg::ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          legal = 1'b1;
          cmd   = rename_pkg::ALU_SRA;
        end
      end
      OPC_OP_IMM: begin
        op2_sel = rename_pkg::OP2_IMM;
        cmd     = base_cmd;
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          if (funct7[5]) begin
            cmd = rename_pkg::ALU_SRA;
          end
        end else begin
          legal = 1'b1;
        end
      end
      default: legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc            <= '0;
      illegal_instr <= 1'b0;
      dec.valid     <= 1'b0;
    end else begin
      if (instr_valid) begin
        pc <= pc + 32'd4;
      end
      illegal_instr <= instr_valid && !legal;
      dec.valid     <= instr_valid && legal;
    end
  end

  always_ff @(posedge clk) begin
    dec.rs1      <= instruction[19:15];
    dec.rs2      <= instruction[24:20];
    dec.rd       <= instruction[11:7];
    dec.alu_cmd  <= cmd;
    dec.op2_type <= op2_sel;
    dec.imm      <= {{20{instruction[31]}}, instruction[31:20]};
  end

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                  clk,
  input  logic                  rst,
  uop_if.sink                   uop,
  output logic                  commit_valid,
  output rename_pkg::arch_reg_t commit_rd,
  output rename_pkg::word_t     commit_data,
  output logic                  free_valid,
  output rename_pkg::phys_reg_t free_reg
);

  rename_pkg::word_t     rf_data1;
  rename_pkg::word_t     rf_data2;
  rename_pkg::word_t     op1;
  rename_pkg::word_t     op2;
  rename_pkg::word_t     alu_out;
  rename_pkg::word_t     exe_result;

  // Read register, feeds the ALU
  logic                  rr_valid;
  rename_pkg::alu_cmd_t  rr_cmd;
  rename_pkg::word_t     rr_op1;
  rename_pkg::word_t     rr_op2;
  rename_pkg::phys_reg_t rr_prd;
  rename_pkg::phys_reg_t rr_old_prd;
  rename_pkg::arch_reg_t rr_rd;

  // Execute register, result waiting for writeback
  logic                  ex_valid;
  rename_pkg::word_t     ex_data;
  rename_pkg::phys_reg_t ex_prd;
  rename_pkg::phys_reg_t ex_old_prd;
  rename_pkg::arch_reg_t ex_rd;

  // Writeback register
  logic                  wb_valid;
  rename_pkg::word_t     wb_data;
  rename_pkg::phys_reg_t wb_prd;
  rename_pkg::phys_reg_t wb_old_prd;
  rename_pkg::arch_reg_t wb_rd;

  phys_regfile u_regfile (
    .clk,
    .rst,
    .raddr1 (uop.prs1),
    .raddr2 (uop.prs2),
    .rdata1 (rf_data1),
    .rdata2 (rf_data2),
    .we     (wb_valid),
    .waddr  (wb_prd),
    .wdata  (wb_data)
  );

  // Youngest producer wins
  function automatic rename_pkg::word_t bypass(input rename_pkg::phys_reg_t tag,
                                               input rename_pkg::word_t rf_val);
    if (rr_valid && rr_prd == tag) begin
      return exe_result;
    end
    if (ex_valid && ex_prd == tag) begin
      return ex_data;
    end
    return rf_val;
  endfunction

  always_comb begin
    op1 = bypass(uop.prs1, rf_data1);
    if (uop.op2_type == rename_pkg::OP2_IMM) begin
      op2 = uop.imm;
    end else begin
      op2 = bypass(uop.prs2, rf_data2);
    end
  end

  always_comb begin
    case (rr_cmd)
      rename_pkg::ALU_ADD:  alu_out = rr_op1 + rr_op2;
      rename_pkg::ALU_SUB:  alu_out = rr_op1 - rr_op2;
      rename_pkg::ALU_SLL:  alu_out = rr_op1 << rr_op2[4:0];
      rename_pkg::ALU_SLT:  alu_out = {31'b0, $signed(rr_op1) < $signed(rr_op2)};
      rename_pkg::ALU_SLTU: alu_out = {31'b0, rr_op1 < rr_op2};
      rename_pkg::ALU_XOR:  alu_out = rr_op1 ^ rr_op2;
      rename_pkg::ALU_SRL:  alu_out = rr_op1 >> rr_op2[4:0];
      rename_pkg::ALU_SRA:  alu_out = rename_pkg::word_t'($signed(rr_op1) >>> rr_op2[4:0]);
      rename_pkg::ALU_OR:   alu_out = rr_op1 | rr_op2;
      rename_pkg::ALU_AND:  alu_out = rr_op1 & rr_op2;
      default:              alu_out = '0;
    endcase
  end

  // A result bound for x0 is forced to zero
  assign exe_result = (rr_prd == '0) ? '0 : alu_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_valid <= 1'b0;
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      rr_valid <= uop.valid;
      ex_valid <= rr_valid;
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    rr_cmd     <= uop.alu_cmd;
    rr_op1     <= op1;
    rr_op2     <= op2;
    rr_prd     <= uop.prd;
    rr_old_prd <= uop.old_prd;
    rr_rd      <= uop.rd;
    ex_data    <= exe_result;
    ex_prd     <= rr_prd;
    ex_old_prd <= rr_old_prd;
    ex_rd      <= rr_rd;
    wb_data    <= ex_data;
    wb_prd     <= ex_prd;
    wb_old_prd <= ex_old_prd;
    wb_rd      <= ex_rd;
  end

  assign commit_valid = wb_valid;
  assign commit_rd    = wb_rd;
  assign commit_data  = wb_data;

  // Previous mapping of rd is dead once this commits
  assign free_valid = wb_valid && (wb_rd != '0);
  assign free_reg   = wb_old_prd;

endmodule

//--- free_list.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module free_list (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  rename_pkg::phys_reg_t push_reg,
  input  logic                  pop,
  output rename_pkg::phys_reg_t pop_reg
);

  localparam int PTR_W = $clog2(`FREE_DEPTH);

  rename_pkg::phys_reg_t slots [`FREE_DEPTH];
  logic [PTR_W-1:0]      head;
  logic [PTR_W-1:0]      tail;
  logic [PTR_W:0]        count;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = push && (count != `FREE_DEPTH);
  assign do_pop  = pop && (count != '0);
  assign pop_reg = slots[head];

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= `FREE_DEPTH;
      // Every register above the architectural set starts free
      for (int i = 0; i < `FREE_DEPTH; i++) begin
        slots[i] <= rename_pkg::phys_reg_t'(`ARCH_REGS + i);
      end
    end else begin
      if (do_push) begin
        slots[tail] <= push_reg;
        tail        <= tail + 1'b1;
      end
      if (do_pop) begin
        head <= head + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- phys_regfile.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module phys_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  rename_pkg::phys_reg_t raddr1,
  input  rename_pkg::phys_reg_t raddr2,
  output rename_pkg::word_t     rdata1,
  output rename_pkg::word_t     rdata2,
  input  logic                  we,
  input  rename_pkg::phys_reg_t waddr,
  input  rename_pkg::word_t     wdata
);

  rename_pkg::word_t regs [`PHYS_REGS];

  function automatic rename_pkg::word_t read_port(input rename_pkg::phys_reg_t addr);
    if (addr == '0) begin
      return '0;
    end
    // Same-cycle write is passed straight through
    if (we && waddr == addr) begin
      return wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

//--- pipe_ifs.sv
`timescale 1ns/1ps

// Decoded instruction, decode to rename
interface decode_if;
  logic                  valid;
  rename_pkg::arch_reg_t rs1;
  rename_pkg::arch_reg_t rs2;
  rename_pkg::arch_reg_t rd;
  rename_pkg::alu_cmd_t  alu_cmd;
  rename_pkg::op2_type_t op2_type;
  rename_pkg::word_t     imm;

  modport src(output valid, rs1, rs2, rd, alu_cmd, op2_type, imm);
  modport sink(input valid, rs1, rs2, rd, alu_cmd, op2_type, imm);
endinterface

// Renamed micro-op, rename to execute
interface uop_if;
  logic                  valid;
  rename_pkg::alu_cmd_t  alu_cmd;
  rename_pkg::phys_reg_t prs1;
  rename_pkg::phys_reg_t prs2;
  rename_pkg::op2_type_t op2_type;
  rename_pkg::word_t     imm;
  rename_pkg::phys_reg_t prd;
  rename_pkg::phys_reg_t old_prd;
  rename_pkg::arch_reg_t rd;

  modport src(output valid, alu_cmd, prs1, prs2, op2_type, imm, prd, old_prd, rd);
  modport sink(input valid, alu_cmd, prs1, prs2, op2_type, imm, prd, old_prd, rd);
endinterface

//--- rename_chk.sv
`timescale 1ns/1ps

module rename_chk (
  input logic              clk,
  input logic              rst,
  input logic              instr_valid,
  input rename_pkg::word_t pc,
  input logic              illegal_instr,
  input logic              commit_valid
);

  int fail_count = 0;

  reset_clears: assert property (@(posedge clk)
    rst |=> (pc == '0) && !commit_valid && !illegal_instr)
    else begin
      $error("pc or output strobes not cleared by reset");
      fail_count++;
    end

  pc_steps: assert property (@(posedge clk) disable iff (rst)
    instr_valid |=> pc == $past(pc) + 32'd4)
    else begin
      $error("pc did not advance by 4 on an instruction strobe");
      fail_count++;
    end

  pc_holds: assert property (@(posedge clk) disable iff (rst)
    !instr_valid |=> pc == $past(pc))
    else begin
      $error("pc changed without an instruction strobe");
      fail_count++;
    end

  // Legal instruction at edge E commits in the cycle after E+4
  commit_in_four: assert property (@(posedge clk) disable iff (rst)
    instr_valid ##1 !illegal_instr |-> ##4 commit_valid)
    else begin
      $error("legal instruction did not commit four cycles after it was sampled");
      fail_count++;
    end

  commit_has_source: assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> $past(instr_valid, 5) && !$past(illegal_instr, 4))
    else begin
      $error("commit without a legal instruction four cycles earlier");
      fail_count++;
    end

  illegal_follows_strobe: assert property (@(posedge clk) disable iff (rst)
    illegal_instr |-> $past(instr_valid))
    else begin
      $error("illegal_instr raised without an instruction strobe");
      fail_count++;
    end

endmodule

bind rename_core rename_chk u_chk (
  .clk,
  .rst,
  .instr_valid,
  .pc,
  .illegal_instr,
  .commit_valid
);

//--- rename_core.sv
`timescale 1ns/1ps

module rename_core (
  input  logic                  clk,
  input  logic                  rst,
  input  rename_pkg::word_t     instruction,
  input  logic                  instr_valid,
  output rename_pkg::word_t     pc,
  output logic                  illegal_instr,
  output logic                  commit_valid,
  output rename_pkg::arch_reg_t commit_rd,
  output rename_pkg::word_t     commit_data
);

  decode_if dec_bus ();
  uop_if    uop_bus ();

  // Register release path, commit back to rename
  logic                  free_valid;
  rename_pkg::phys_reg_t free_reg;

  decode_stage u_decode (
    .clk,
    .rst,
    .instruction,
    .instr_valid,
    .pc,
    .illegal_instr,
    .dec (dec_bus.src)
  );

  rename_unit u_rename (
    .clk,
    .rst,
    .dec        (dec_bus.sink),
    .uop        (uop_bus.src),
    .free_valid (free_valid),
    .free_reg   (free_reg)
  );

  exec_unit u_exec (
    .clk,
    .rst,
    .uop          (uop_bus.sink),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .free_valid   (free_valid),
    .free_reg     (free_reg)
  );

endmodule

//--- rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Register counts and widths of the rename core
`define ARCH_REGS      32
`define PHYS_REGS      48
`define PHYS_REG_WIDTH 6
`define FREE_DEPTH     16

`endif

//--- rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] arch_reg_t;
  typedef logic [`PHYS_REG_WIDTH-1:0] phys_reg_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_cmd_t;

  // Second ALU operand source
  typedef enum logic {
    OP2_REG,
    OP2_IMM
  } op2_type_t;

endpackage

//--- rename_unit.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_unit (
  input logic                  clk,
  input logic                  rst,
  decode_if.sink               dec,
  uop_if.src                   uop,
  input logic                  free_valid,
  input rename_pkg::phys_reg_t free_reg
);

  rename_pkg::phys_reg_t map_table [`ARCH_REGS];
  rename_pkg::phys_reg_t new_prd;
  logic                  alloc;

  // x0 never allocates
  assign alloc = dec.valid && (dec.rd != '0);

  free_list u_free_list (
    .clk,
    .rst,
    .push     (free_valid),
    .push_reg (free_reg),
    .pop      (alloc),
    .pop_reg  (new_prd)
  );

  // Identity map after reset, entry 0 stays pinned to physical 0
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ARCH_REGS; i++) begin
        map_table[i] <= rename_pkg::phys_reg_t'(i);
      end
    end else if (alloc) begin
      map_table[dec.rd] <= new_prd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uop.valid <= 1'b0;
    end else begin
      uop.valid <= dec.valid;
    end
  end

  // Sources see the mapping from before this instruction
  always_ff @(posedge clk) begin
    uop.alu_cmd  <= dec.alu_cmd;
    uop.prs1     <= map_table[dec.rs1];
    uop.prs2     <= map_table[dec.rs2];
    uop.op2_type <= dec.op2_type;
    uop.imm      <= dec.imm;
    uop.prd      <= alloc ? new_prd : '0;
    uop.old_prd  <= map_table[dec.rd];
    uop.rd       <= dec.rd;
  end

endmodule

//--- tb.f
+incdir+.
rename_pkg.sv
pipe_ifs.sv
decode_stage.sv
free_list.sv
rename_unit.sv
phys_regfile.sv
exec_unit.sv
rename_core.sv
rename_chk.sv
tb_rename_core.sv

//--- tb_rename_core.sv
`timescale 1ns/1ps

module tb_rename_core;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam int DIRECTED_INSTRS = 38;
  localparam int RANDOM_INSTRS   = 200;
  // Reset plus the idle cycles of each test's drain
  localparam int OVERHEAD_CYCLES = 80;
  localparam int WATCHDOG_NS =
    (DIRECTED_INSTRS + RANDOM_INSTRS + OVERHEAD_CYCLES + 20) * 20;

  logic                  clk;
  logic                  rst;
  rename_pkg::word_t     instruction;
  logic                  instr_valid;
  rename_pkg::word_t     pc;
  logic                  illegal_instr;
  logic                  commit_valid;
  rename_pkg::arch_reg_t commit_rd;
  rename_pkg::word_t     commit_data;

  integer                seed;
  int                    checks;
  int                    errors;
  int                    mark;
  int                    sent;
  int                    illegal_sent;
  int                    illegal_seen;
  rename_pkg::word_t     arch [32];
  rename_pkg::arch_reg_t exp_rd_q [$];
  rename_pkg::word_t     exp_data_q [$];

  rename_core uut (
    .clk,
    .rst,
    .instruction,
    .instr_valid,
    .pc,
    .illegal_instr,
    .commit_valid,
    .commit_rd,
    .commit_data
  );

  always #10 clk = ~clk;

  function automatic rename_pkg::word_t r_type(input logic [6:0] f7, input int rs2,
                                               input int rs1, input logic [2:0] f3,
                                               input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic rename_pkg::word_t i_type(input logic [11:0] imm, input int rs1,
                                               input logic [2:0] f3, input int rd);
    return {imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
  endfunction

  // funct7 and funct3 of ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  function automatic logic [9:0] r_op_code(input int idx);
    case (idx)
      0: return {7'h00, 3'd0};
      1: return {7'h20, 3'd0};
      2: return {7'h00, 3'd1};
      3: return {7'h00, 3'd2};
      4: return {7'h00, 3'd3};
      5: return {7'h00, 3'd4};
      6: return {7'h00, 3'd5};
      7: return {7'h20, 3'd5};
      8: return {7'h00, 3'd6};
      default: return {7'h00, 3'd7};
    endcase
  endfunction

  function automatic logic [11:0] rand_imm();
    return 12'($random(seed));
  endfunction

  function automatic logic legal_encoding(input rename_pkg::word_t instr);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = instr[31:25];
    f3 = instr[14:12];
    if (instr[6:0] == OPC_OP) begin
      return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    end
    if (instr[6:0] == OPC_OP_IMM) begin
      if (f3 == 3'd1) return f7 == 7'h00;
      if (f3 == 3'd5) return f7 == 7'h00 || f7 == 7'h20;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // RV32I result against the architectural register model
  function automatic rename_pkg::word_t expected_result(input rename_pkg::word_t instr);
    rename_pkg::word_t a;
    rename_pkg::word_t b;
    logic              is_reg;
    is_reg = (instr[6:0] == OPC_OP);
    a = arch[instr[19:15]];
    b = is_reg ? arch[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
    case (instr[14:12])
      3'd0: return (is_reg && instr[30]) ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return instr[30] ? rename_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic rename_pkg::word_t random_instr();
    int         kind;
    int         rd;
    int         rs1;
    int         rs2;
    logic [9:0] op;
    logic [4:0] sh;
    kind = $unsigned($random(seed)) % 10;
    rd   = $unsigned($random(seed)) % 16;
    rs1  = $unsigned($random(seed)) % 16;
    rs2  = $unsigned($random(seed)) % 16;
    op   = r_op_code($unsigned($random(seed)) % 10);
    sh   = 5'($random(seed));
    // Load opcode, not supported
    if (kind == 0) return {rand_imm(), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    if (kind < 5) return r_type(op[9:3], rs2, rs1, op[2:0], rd);
    if (op[2:0] == 3'd1 || op[2:0] == 3'd5) return i_type({op[9:3], sh}, rs1, op[2:0], rd);
    return i_type(rand_imm(), rs1, op[2:0], rd);
  endfunction

  function automatic int total_errors();
    return errors + uut.u_chk.fail_count;
  endfunction

  task automatic send(input rename_pkg::word_t instr);
    rename_pkg::word_t result;
    @(negedge clk);
    instruction = instr;
    instr_valid = 1'b1;
    sent++;
    if (legal_encoding(instr)) begin
      result = (instr[11:7] == 5'd0) ? '0 : expected_result(instr);
      if (instr[11:7] != 5'd0) arch[instr[11:7]] = result;
      exp_rd_q.push_back(instr[11:7]);
      exp_data_q.push_back(result);
    end else begin
      illegal_sent++;
    end
  endtask

  task automatic finish_test(input string name);
    int waited;
    @(negedge clk);
    instr_valid = 1'b0;
    waited = 0;
    while (exp_rd_q.size() != 0 && waited < 12) begin
      @(posedge clk);
      waited++;
    end
    repeat (2) @(posedge clk);
    checks += 3;
    assert (exp_rd_q.size() == 0) else begin
      $display("%0t: %0d expected commits never arrived", $time, exp_rd_q.size());
      errors++;
      exp_rd_q.delete();
      exp_data_q.delete();
    end
    assert (pc == rename_pkg::word_t'(4 * sent)) else begin
      $display("Mismatch at %0t: pc got %h expected %h", $time, pc, 4 * sent);
      errors++;
    end
    assert (illegal_seen == illegal_sent) else begin
      $display("Mismatch at %0t: illegal_instr pulses got %0d expected %0d",
               $time, illegal_seen, illegal_sent);
      errors++;
    end
    $display("Test %s finished, %0d errors", name, total_errors() - mark);
    mark = total_errors();
  endtask

  // Scoreboard, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (illegal_instr) illegal_seen++;
    if (commit_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("%0t: commit to x%0d with no instruction outstanding", $time, commit_rd);
        errors++;
      end else begin
        checks++;
        assert (commit_rd == exp_rd_q[0]) else begin
          $display("Mismatch at %0t: commit_rd got %0d expected %0d",
                   $time, commit_rd, exp_rd_q[0]);
          errors++;
        end
        assert (commit_data == exp_data_q[0]) else begin
          $display("Mismatch at %0t: commit_data got %h expected %h",
                   $time, commit_data, exp_data_q[0]);
          errors++;
        end
        void'(exp_rd_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, the run did not finish", $time);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic [9:0] op;
    clk          = 1'b0;
    rst          = 1'b1;
    instruction  = '0;
    instr_valid  = 1'b0;
    seed         = 32'he166_b931;
    checks       = 0;
    errors       = 0;
    mark         = 0;
    sent         = 0;
    illegal_sent = 0;
    illegal_seen = 0;
    for (int i = 0; i < 32; i++) begin
      arch[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    finish_test("reset");

    send(i_type(rand_imm(), 0, 3'b000, 1));
    send(i_type(rand_imm(), 0, 3'b000, 2));
    send(i_type(rand_imm(), 1, 3'b010, 3));
    send(i_type(rand_imm(), 1, 3'b011, 4));
    send(i_type(rand_imm(), 2, 3'b100, 5));
    send(i_type(rand_imm(), 1, 3'b110, 6));
    send(i_type(rand_imm(), 2, 3'b111, 7));
    send(i_type({7'h00, 5'd7}, 1, 3'b001, 8));
    send(i_type({7'h00, 5'd13}, 1, 3'b101, 9));
    send(i_type({7'h20, 5'd13}, 1, 3'b101, 10));
    send(i_type(rand_imm(), 2, 3'b000, 11));
    finish_test("immediate_ops");

    // Chain through x12/x13, producer distance cycles 1, 2, 3
    for (int i = 0; i < 10; i++) begin
      op = r_op_code(i);
      send(r_type(op[9:3], 2, 12 + (i + 1) % 2, op[2:0], 12 + i % 2));
      repeat (i % 3) send(i_type(rand_imm(), 0, 3'b000, 20 + i % 3));
    end
    finish_test("dependent_chain");

    send(i_type(12'd55, 1, 3'b000, 0));
    send(r_type(7'h00, 2, 1, 3'b000, 0));
    send(r_type(7'h00, 1, 0, 3'b000, 15));
    send(i_type(12'd0, 0, 3'b110, 16));
    send(r_type(7'h00, 0, 0, 3'b110, 17));
    finish_test("x0_writes");

    send({12'h004, 5'd1, 3'b010, 5'd3, 7'b0000011});
    send(r_type(7'h01, 2, 1, 3'b000, 4));
    send(i_type({7'h20, 5'd3}, 1, 3'b001, 5));
    repeat (RANDOM_INSTRS) send(random_instr());
    finish_test("illegal_and_random");

    $display("Checks: %0d, scoreboard errors: %0d, assertion failures: %0d",
             checks, errors, uut.u_chk.fail_count);
    if (total_errors() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
